//--- Makefile
# Verilator build and run of the MiniRISC bus system testbench

VERILATOR ?= verilator
TOP       ?= tb_minirisc_system
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SIM_BIN = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- common/minirisc_bus_pkg.sv
// MiniRISC data-memory bus types
// Address and data bytes, one master request and the DMA FSM states
`include "minirisc_consts.svh"

package minirisc_bus_pkg;

   // Single bus address
   typedef logic [`MR_ADDR_W-1:0] bus_addr_t;

   // Single bus byte
   typedef logic [`MR_DATA_W-1:0] bus_data_t;

   // One master request for one cycle
   // Only counts in a cycle where the master holds the grant
   typedef struct packed {
      bus_addr_t addr;     // Target address
      logic      wr;       // Write strobe
      logic      rd;       // Read strobe
      bus_data_t data;     // Write data
   } bus_req_t;

   // DMA copy FSM
   typedef enum logic [1:0] {
      IDLE,                // Waiting for a start write
      READ,                // Fetching one source byte
      WRITE,               // Storing it at the destination
      DONE                 // Sets the done flag for one cycle
   } dma_state_t;

endpackage

//--- common/minirisc_consts.svh
// MiniRISC bus constants
// Widths, memory depth and slave base addresses of the data-memory bus
`ifndef MINIRISC_CONSTS_SVH
`define MINIRISC_CONSTS_SVH

//**************************************************************************
// Bus geometry
//**************************************************************************
`define MR_DATA_W      8        // One bus byte
`define MR_ADDR_W      8        // 256-byte address space

//**************************************************************************
// Data memory
//**************************************************************************
// Lower half of the address space, selected by address bit 7 low
`define MR_DMEM_DEPTH  128

//**************************************************************************
// Peripheral base addresses
//**************************************************************************
`define MR_LED_ADDR    8'h80    // LED register, read/write
`define MR_DIP_ADDR    8'h81    // DIP switches, read only
`define MR_TMR_BASE    8'h82    // Timer reload and control/status

// DMA source, destination, count and control/status
// Occupies four bytes 0x8C to 0x8F
`define MR_DMA_BASE    8'h8C

`endif

//--- dma/dma_controller.sv
// DMA controller
// Register slave at 0x8C to 0x8F and a bus master copying one byte per two grants
`include "minirisc_consts.svh"

module dma_controller
   import minirisc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // Slave side, register access
   input  bus_req_t  mst_bus,      // Granted master request
   output bus_data_t dma_rdata,    // Zero unless selected and read

   // Master side, copy traffic
   output logic      dma_req,      // Held while in READ or WRITE
   output bus_req_t  dma_bus,
   input  logic      dma_grant,    // Lost cycles stall the FSM in place
   input  bus_data_t rdata,        // Shared read byte

   output logic      dma_irq       // Done and irq enable
);

   localparam bus_addr_t SRC_ADDR = bus_addr_t'(`MR_DMA_BASE);
   localparam bus_addr_t DST_ADDR = bus_addr_t'(`MR_DMA_BASE + 1);
   localparam bus_addr_t CNT_ADDR = bus_addr_t'(`MR_DMA_BASE + 2);
   localparam bus_addr_t CTL_ADDR = bus_addr_t'(`MR_DMA_BASE + 3);

   dma_state_t state_q;
   bus_addr_t  src_q;              // Next source address
   bus_addr_t  dst_q;              // Next destination address
   bus_data_t  cnt_q;              // Bytes left
   bus_data_t  data_q;             // Byte in flight
   logic       irq_en_q;
   logic       done_q;

   logic       busy;
   logic       ctl_wr;
   logic       stat_rd;
   logic       start;
   logic       last_byte;

   assign busy      = (state_q != IDLE);
   assign ctl_wr    = mst_bus.wr && (mst_bus.addr == CTL_ADDR);
   assign stat_rd   = mst_bus.rd && (mst_bus.addr == CTL_ADDR);
   assign start     = ctl_wr && mst_bus.data[0] && !busy;   // Ignored while busy
   assign last_byte = (cnt_q == bus_data_t'(1));

   //**************************************************************************
   // Register read mux
   //**************************************************************************
   always_comb
   begin
      dma_rdata = '0;
      if (mst_bus.rd)
      begin
         case (mst_bus.addr)
            SRC_ADDR: dma_rdata = src_q;
            DST_ADDR: dma_rdata = dst_q;
            CNT_ADDR: dma_rdata = cnt_q;
            CTL_ADDR: dma_rdata = {busy, done_q, 4'b0000, irq_en_q, 1'b0};
            default:  dma_rdata = '0;
         endcase
      end
   end

   //**************************************************************************
   // Master request
   //**************************************************************************
   always_comb
   begin
      dma_req = 1'b0;
      dma_bus = '0;
      case (state_q)
         READ:
         begin
            dma_req      = 1'b1;
            dma_bus.addr = src_q;
            dma_bus.rd   = 1'b1;
         end
         WRITE:
         begin
            dma_req      = 1'b1;
            dma_bus.addr = dst_q;
            dma_bus.wr   = 1'b1;
            dma_bus.data = data_q;
         end
         default: dma_req = 1'b0;          // IDLE and DONE stay off the bus
      endcase
   end

   //**************************************************************************
   // Registers and copy FSM
   //**************************************************************************
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state_q  <= IDLE;
         src_q    <= '0;
         dst_q    <= '0;
         cnt_q    <= '0;
         irq_en_q <= 1'b0;
         done_q   <= 1'b0;
      end
      else
      begin
         if (ctl_wr)
            irq_en_q <= mst_bus.data[1];

         // Address and count only programmable while idle
         if (mst_bus.wr && !busy)
         begin
            if (mst_bus.addr == SRC_ADDR)
               src_q <= mst_bus.data;
            if (mst_bus.addr == DST_ADDR)
               dst_q <= mst_bus.data;
            if (mst_bus.addr == CNT_ADDR)
               cnt_q <= mst_bus.data;
         end

         if (state_q == DONE)
            done_q <= 1'b1;                // Set wins over a status read
         else if (start || stat_rd)
            done_q <= 1'b0;

         case (state_q)
            IDLE:
               if (start)
                  state_q <= (cnt_q == '0) ? DONE : READ;   // Empty copy ends at once
            READ:
               if (dma_grant)
                  state_q <= WRITE;
            WRITE:
               if (dma_grant)
               begin
                  src_q   <= src_q + 1'b1;
                  dst_q   <= dst_q + 1'b1;
                  cnt_q   <= cnt_q - 1'b1;
                  state_q <= last_byte ? DONE : READ;
               end
            default:
               state_q <= IDLE;            // DONE lasts one cycle
         endcase
      end
   end

   // Source byte captured on the granted read edge
   always_ff @(posedge clk)
   begin
      if ((state_q == READ) && dma_grant)
         data_q <= rdata;
   end

   assign dma_irq = done_q & irq_en_q;

   // Every DMA request carries exactly one strobe
   a_dma_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
      dma_req |-> (dma_bus.rd ^ dma_bus.wr))
      else $error("dma_controller: request with bad strobes");

endmodule

//--- src.f
+incdir+common
common/minirisc_bus_pkg.sv
src/bus_interconnect.sv
src/data_mem.sv
src/io_regs.sv
src/basic_timer.sv
dma/dma_controller.sv
src/minirisc_system.sv
test/tb_minirisc_system.sv

//--- src/basic_timer.sv
// Timer slave
// Reloadable down counter, wrap flag and interrupt, registers at 0x82 to 0x83
`include "minirisc_consts.svh"

module basic_timer
   import minirisc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  mst_bus,      // Granted master request
   output bus_data_t tmr_rdata,    // Zero unless selected and read
   output logic      tmr_irq       // Flag and irq enable
);

   localparam bus_addr_t RLD_ADDR = bus_addr_t'(`MR_TMR_BASE);      // Reload / count
   localparam bus_addr_t CTL_ADDR = bus_addr_t'(`MR_TMR_BASE + 1);  // Control / status

   bus_data_t reload_q;            // Period minus one
   bus_data_t cnt_q;               // Current count
   logic      en_q;                // Control bit 0
   logic      irq_en_q;            // Control bit 1
   logic      flag_q;              // Status bit 7

   logic      rld_wr;
   logic      ctl_wr;
   logic      stat_rd;
   logic      tmr_wrap;

   assign rld_wr   = mst_bus.wr && (mst_bus.addr == RLD_ADDR);
   assign ctl_wr   = mst_bus.wr && (mst_bus.addr == CTL_ADDR);
   assign stat_rd  = mst_bus.rd && (mst_bus.addr == CTL_ADDR);
   assign tmr_wrap = en_q && (cnt_q == '0);   // Count expires this cycle

   //**************************************************************************
   // Registers and counter
   //**************************************************************************
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         reload_q <= '0;
         cnt_q    <= '0;
         en_q     <= 1'b0;
         irq_en_q <= 1'b0;
         flag_q   <= 1'b0;
      end
      else
      begin
         if (rld_wr)
            reload_q <= mst_bus.data;

         if (ctl_wr)
         begin
            en_q     <= mst_bus.data[0];
            irq_en_q <= mst_bus.data[1];
         end

         // Enable from stopped loads the reload value, then one step per cycle
         if (ctl_wr && mst_bus.data[0] && !en_q)
            cnt_q <= reload_q;
         else if (tmr_wrap)
            cnt_q <= reload_q;             // Period is reload+1 cycles
         else if (en_q)
            cnt_q <= cnt_q - 1'b1;

         if (tmr_wrap)
            flag_q <= 1'b1;                // A new wrap wins over the clear
         else if (stat_rd)
            flag_q <= 1'b0;                // Cleared by the status read
      end
   end

   //**************************************************************************
   // Read mux and interrupt
   //**************************************************************************
   always_comb
   begin
      tmr_rdata = '0;
      if (mst_bus.rd && (mst_bus.addr == RLD_ADDR))
         tmr_rdata = cnt_q;
      else if (stat_rd)
         tmr_rdata = {flag_q, 5'b00000, irq_en_q, en_q};
   end

   assign tmr_irq = flag_q & irq_en_q;

   // Flag can only be set by a wrap of a running counter
   a_flag_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(flag_q) |-> $past(en_q))
      else $error("basic_timer: flag set while disabled");

endmodule

//--- src/bus_interconnect.sv
// Data-memory bus interconnect
// Fixed-priority arbiter, granted request mux, read-data OR and interrupt OR
module bus_interconnect
   import minirisc_bus_pkg::*;
(
   // Masters
   input  logic      cpu_req,      // Highest priority
   input  bus_req_t  cpu_bus,
   input  logic      dma_req,
   input  bus_req_t  dma_bus,
   output logic      cpu_grant,
   output logic      dma_grant,

   // Towards the slaves
   output bus_req_t  mst_bus,

   // Slave read bytes
   input  bus_data_t mem_rdata,
   input  bus_data_t io_rdata,
   input  bus_data_t tmr_rdata,
   input  bus_data_t dma_rdata,
   output bus_data_t rdata,

   // Interrupt sources
   input  logic      tmr_irq,
   input  logic      dma_irq,
   output logic      irq
);

   //**************************************************************************
   // Arbitration and request mux
   //**************************************************************************
   always_comb
   begin
      cpu_grant = cpu_req;                 // External master always wins
      dma_grant = dma_req & ~cpu_req;      // DMA only on idle cycles

      if (cpu_grant)
         mst_bus = cpu_bus;
      else if (dma_grant)
         mst_bus = dma_bus;
      else
         mst_bus = '0;                     // No strobes when nobody owns the bus

      // At most one strobe on the slave bus
      assert (!(mst_bus.rd && mst_bus.wr))
         else $error("bus_interconnect: read and write strobes together");
   end

   //**************************************************************************
   // Read data and interrupts
   //**************************************************************************
   // Unselected slaves drive zero, so OR acts as the read mux
   assign rdata = mem_rdata | io_rdata | tmr_rdata | dma_rdata;

   assign irq = tmr_irq | dma_irq;         // Level sensitive, active high

endmodule

//--- src/data_mem.sv
// Data memory slave
// 128 x 8 array, write on the clock edge, combinational read
`include "minirisc_consts.svh"

module data_mem
   import minirisc_bus_pkg::*;
(
   input  logic      clk,
   input  bus_req_t  mst_bus,      // Granted master request
   output bus_data_t mem_rdata     // Zero unless selected and read
);

   localparam int DMEM_AW = $clog2(`MR_DMEM_DEPTH);   // 7 index bits

   bus_data_t          mem [`MR_DMEM_DEPTH];          // Storage, no reset
   logic [DMEM_AW-1:0] mem_addr;
   logic               mem_sel;

   // Lower half of the address map
   assign mem_sel  = ~mst_bus.addr[`MR_ADDR_W-1];
   assign mem_addr = mst_bus.addr[DMEM_AW-1:0];

   // Write lands at the edge ending the bus cycle
   always_ff @(posedge clk)
   begin
      if (mst_bus.wr && mem_sel)
         mem[mem_addr] <= mst_bus.data;
   end

   // Same-cycle read
   assign mem_rdata = (mst_bus.rd && mem_sel) ? mem[mem_addr] : '0;

endmodule

//--- src/io_regs.sv
// LED output register and DIP-switch input slave
// LEDs at 0x80 are read/write, switches at 0x81 are read only
`include "minirisc_consts.svh"

module io_regs
   import minirisc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  mst_bus,      // Granted master request
   input  bus_data_t sw,           // DIP switch levels
   output bus_data_t ld,           // LED drive
   output bus_data_t io_rdata      // Zero unless selected and read
);

   bus_data_t led_q;
   logic      led_sel;
   logic      dip_sel;

   assign led_sel = (mst_bus.addr == `MR_LED_ADDR);
   assign dip_sel = (mst_bus.addr == `MR_DIP_ADDR);

   // LED register
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         led_q <= '0;                      // LEDs dark after reset
      else if (mst_bus.wr && led_sel)
         led_q <= mst_bus.data;
   end

   assign ld = led_q;

   // Read mux, writes to the switch address fall through
   always_comb
   begin
      io_rdata = '0;
      if (mst_bus.rd && led_sel)
         io_rdata = led_q;                 // Read back
      else if (mst_bus.rd && dip_sel)
         io_rdata = sw;                    // Live switch value
   end

endmodule

//--- src/minirisc_system.sv
// MiniRISC system top level, data-memory bus side
// External master and DMA share one bus to memory, I/O, timer and DMA registers
module minirisc_system
   import minirisc_bus_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,

   // External bus master standing in for the CPU
   input  logic      cpu_req,      // Bus request, level
   input  bus_req_t  cpu_bus,      // Address, strobes and write data
   output logic      cpu_grant,    // Always granted while requesting
   output bus_data_t rdata,        // Shared read byte

   // Board I/O
   input  bus_data_t sw,           // DIP switches
   output bus_data_t ld,           // LEDs

   output logic      irq           // Timer or DMA interrupt
);

   //**************************************************************************
   // Bus wiring
   //**************************************************************************
   logic      dma_req;
   logic      dma_grant;
   bus_req_t  dma_bus;             // DMA master request
   bus_req_t  mst_bus;             // Granted request towards the slaves

   // Per-slave read bytes, zero unless selected and read
   bus_data_t mem_rdata;
   bus_data_t io_rdata;
   bus_data_t tmr_rdata;
   bus_data_t dma_rdata;

   logic      tmr_irq;
   logic      dma_irq;

   // Arbiter, request mux, read-data OR, interrupt OR
   bus_interconnect bus_ic (
      .cpu_req   (cpu_req),
      .cpu_bus   (cpu_bus),
      .dma_req   (dma_req),
      .dma_bus   (dma_bus),
      .cpu_grant (cpu_grant),
      .dma_grant (dma_grant),
      .mst_bus   (mst_bus),
      .mem_rdata (mem_rdata),
      .io_rdata  (io_rdata),
      .tmr_rdata (tmr_rdata),
      .dma_rdata (dma_rdata),
      .rdata     (rdata),
      .tmr_irq   (tmr_irq),
      .dma_irq   (dma_irq),
      .irq       (irq)
   );

   //**************************************************************************
   // Slaves
   //**************************************************************************
   data_mem dmem (                 // 0x00 to 0x7F
      .clk       (clk),
      .mst_bus   (mst_bus),
      .mem_rdata (mem_rdata)
   );

   io_regs io (                    // LEDs 0x80, switches 0x81
      .clk      (clk),
      .rst_n    (rst_n),
      .mst_bus  (mst_bus),
      .sw       (sw),
      .ld       (ld),
      .io_rdata (io_rdata)
   );

   basic_timer timer (             // 0x82 to 0x83
      .clk       (clk),
      .rst_n     (rst_n),
      .mst_bus   (mst_bus),
      .tmr_rdata (tmr_rdata),
      .tmr_irq   (tmr_irq)
   );

   // Register slave at 0x8C to 0x8F and second bus master
   dma_controller dma (
      .clk       (clk),
      .rst_n     (rst_n),
      .mst_bus   (mst_bus),
      .dma_rdata (dma_rdata),
      .dma_req   (dma_req),
      .dma_bus   (dma_bus),
      .dma_grant (dma_grant),
      .rdata     (rdata),        // Same shared read byte the CPU sees
      .dma_irq   (dma_irq)
   );

endmodule

//--- test/tb_minirisc_system.sv
// Testbench for the MiniRISC data-memory bus system
// Table of bus steps applied in a loop, watchdog and typed compares
`include "minirisc_consts.svh"

module tb_minirisc_system import minirisc_bus_pkg::*; ();

   localparam int        CLK_PERIOD = 100;
   localparam int        DRIVE_DLY  = 5;      // Input skew after the rising edge
   localparam int        RST_CYCLES = 4;
   localparam int        N_TESTS    = 6;
   localparam bit [31:0] SEED       = 32'he236_d8cf;

   localparam bus_addr_t LED_ADDR = bus_addr_t'(`MR_LED_ADDR);
   localparam bus_addr_t DIP_ADDR = bus_addr_t'(`MR_DIP_ADDR);
   localparam bus_addr_t TMR_RLD  = bus_addr_t'(`MR_TMR_BASE);
   localparam bus_addr_t TMR_CTL  = bus_addr_t'(`MR_TMR_BASE + 1);
   localparam bus_addr_t DMA_SRC  = bus_addr_t'(`MR_DMA_BASE);
   localparam bus_addr_t DMA_DST  = bus_addr_t'(`MR_DMA_BASE + 1);
   localparam bus_addr_t DMA_CNT  = bus_addr_t'(`MR_DMA_BASE + 2);
   localparam bus_addr_t DMA_CTL  = bus_addr_t'(`MR_DMA_BASE + 3);

   typedef enum logic [2:0] {OP_WR, OP_RD, OP_POLL, OP_SW, OP_IRQ, OP_LD} op_t;

   // One table row
   typedef struct packed {
      op_t        op;
      logic [3:0] test;
      bus_addr_t  addr;
      bus_data_t  data;       // Write data, switch value, poll irq check in bit 0
      bus_data_t  mask;       // Bits compared on reads and polls
      bus_data_t  exp;        // Expected value, irq level in bit 0
   } step_t;

   logic      clk;
   logic      rst_n;
   logic      cpu_req;
   bus_req_t  cpu_bus;
   logic      cpu_grant;
   bus_data_t rdata;
   bus_data_t sw;
   bus_data_t ld;
   logic      irq;

   step_t     steps [$];
   bus_data_t shadow [`MR_DMEM_DEPTH];   // Expected memory contents
   string     test_name [N_TESTS] = '{"reset", "memory", "io", "timer", "dma", "priority"};
   int        cur_test;
   int        errors;
   int        test_errs;
   int        tests_failed;
   int        checks;
   logic      table_ready;

   minirisc_system dut0 (
      .clk       (clk),
      .rst_n     (rst_n),
      .cpu_req   (cpu_req),
      .cpu_bus   (cpu_bus),
      .cpu_grant (cpu_grant),
      .rdata     (rdata),
      .sw        (sw),
      .ld        (ld),
      .irq       (irq)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   //**************************************************************************
   // Compare tasks
   //**************************************************************************
   task automatic check_data(input string name, input bus_data_t exp, input bus_data_t act);
      checks++;
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %02h got %02h", $time, name, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
         errors++;
         test_errs++;
      end
   endtask

   //**************************************************************************
   // Table construction
   //**************************************************************************
   task automatic add_step(input op_t op, input bus_addr_t addr, input bus_data_t data,
                           input bus_data_t mask, input bus_data_t exp);
      step_t s;
      s.op   = op;
      s.test = 4'(cur_test);
      s.addr = addr;
      s.data = data;
      s.mask = mask;
      s.exp  = exp;
      steps.push_back(s);
   endtask

   task automatic add_wr(input bus_addr_t addr, input bus_data_t data);
      if (!addr[7])
         shadow[addr[6:0]] = data;                   // Memory model
      add_step(OP_WR, addr, data, 8'h00, 8'h00);
   endtask

   task automatic add_rd(input bus_addr_t addr, input bus_data_t mask, input bus_data_t exp);
      add_step(OP_RD, addr, 8'h00, mask, exp);
   endtask

   task automatic fill_mem(input bus_addr_t base, input int n);
      for (int i = 0; i < n; i++)
         add_wr(bus_addr_t'(base + i), bus_data_t'($urandom));
   endtask

   task automatic expect_mem(input bus_addr_t base, input int n);
      for (int i = 0; i < n; i++)
         add_rd(bus_addr_t'(base + i), 8'hFF, shadow[7'(base + i)]);
   endtask

   // Program and start a copy, destination takes the source bytes
   task automatic add_dma(input bus_addr_t src, input bus_addr_t dst, input int n,
                          input bus_data_t ctl);
      add_wr(DMA_SRC, src);
      add_wr(DMA_DST, dst);
      add_wr(DMA_CNT, bus_data_t'(n));
      add_wr(DMA_CTL, ctl);
      for (int i = 0; i < n; i++)
         shadow[7'(dst + i)] = shadow[7'(src + i)];
   endtask

   task automatic build_table();
      bus_data_t v;
      cur_test = 0;                                  // Inactive outputs after reset
      add_step(OP_LD, 8'h00, 8'h00, 8'hFF, 8'h00);
      add_step(OP_IRQ, 8'h00, 8'h00, 8'h01, 8'h00);
      add_rd(DMA_CTL, 8'hFF, 8'h00);
      cur_test = 1;                                  // Spread over the whole array
      for (int i = 0; i < 8; i++)
         add_wr(bus_addr_t'((i * 17) & 8'h7F), bus_data_t'($urandom));
      add_wr(8'h7F, bus_data_t'($urandom));
      for (int i = 0; i < 8; i++)
         expect_mem(bus_addr_t'((i * 17) & 8'h7F), 1);
      expect_mem(8'h7F, 1);
      add_rd(8'h90, 8'hFF, 8'h00);                   // Unmapped
      cur_test = 2;
      v = bus_data_t'($urandom);
      add_wr(LED_ADDR, v);
      add_step(OP_LD, 8'h00, 8'h00, 8'hFF, v);
      add_rd(LED_ADDR, 8'hFF, v);
      for (int i = 0; i < 2; i++)
      begin
         v = bus_data_t'($urandom);
         add_step(OP_SW, 8'h00, v, 8'h00, 8'h00);
         add_wr(DIP_ADDR, ~v);                       // Read-only, must not stick
         add_rd(DIP_ADDR, 8'hFF, v);
      end
      cur_test = 3;                                  // Period 41 cycles
      add_wr(TMR_RLD, 8'd40);
      add_wr(TMR_CTL, 8'h03);
      add_step(OP_POLL, TMR_CTL, 8'h01, 8'h83, 8'h83);
      add_rd(TMR_CTL, 8'hFF, 8'h03);                 // Flag cleared by the poll hit
      add_step(OP_IRQ, 8'h00, 8'h00, 8'h01, 8'h00);
      add_wr(TMR_CTL, 8'h00);
      cur_test = 4;
      fill_mem(8'h00, 8);
      add_dma(8'h00, 8'h20, 8, 8'h03);
      add_step(OP_POLL, DMA_CTL, 8'h01, 8'hC2, 8'h42);  // Idle, done, irq enabled
      add_rd(DMA_CTL, 8'hFF, 8'h02);
      add_step(OP_IRQ, 8'h00, 8'h00, 8'h01, 8'h00);
      add_rd(DMA_CNT, 8'hFF, 8'h00);
      add_rd(DMA_SRC, 8'hFF, 8'h08);
      expect_mem(8'h20, 8);
      cur_test = 5;
      fill_mem(8'h40, 8);
      add_dma(8'h40, 8'h50, 8, 8'h01);
      add_rd(DMA_CTL, 8'h80, 8'h80);                 // Copy still running
      for (int i = 0; i < 8; i++)
      begin
         v = bus_data_t'($urandom);
         add_wr(bus_addr_t'(8'h70 + i), v);
         add_rd(bus_addr_t'(8'h70 + i), 8'hFF, v);
      end
      add_step(OP_POLL, DMA_CTL, 8'h00, 8'hC0, 8'h40);
      expect_mem(8'h50, 8);
   endtask

   //**************************************************************************
   // Bus driving
   //**************************************************************************
   // One granted cycle, then one idle cycle for the DMA
   task automatic bus_access(input bus_addr_t addr, input logic write, input bus_data_t data,
                             output bus_data_t rd_val, output logic irq_val);
      logic grant;
      cpu_req      = 1'b1;
      cpu_bus.addr = addr;
      cpu_bus.wr   = write;
      cpu_bus.rd   = !write;
      cpu_bus.data = write ? data : 8'h00;
      @(negedge clk);                                // Settled mid-cycle
      rd_val  = rdata;
      irq_val = irq;
      grant   = cpu_grant;
      check_bit("cpu_grant", 1'b1, grant);
      @(posedge clk);
      #DRIVE_DLY;
      cpu_req = 1'b0;
      cpu_bus = '0;
      @(posedge clk);
      #DRIVE_DLY;
   endtask

   task automatic run_step(input step_t s);
      bus_data_t rd_val;
      logic      irq_val;
      case (s.op)
         OP_WR:
            bus_access(s.addr, 1'b1, s.data, rd_val, irq_val);
         OP_RD:
         begin
            bus_access(s.addr, 1'b0, 8'h00, rd_val, irq_val);
            check_data($sformatf("rdata@%02h", s.addr), s.exp & s.mask, rd_val & s.mask);
         end
         OP_POLL:
         begin
            do
               bus_access(s.addr, 1'b0, 8'h00, rd_val, irq_val);
            while ((rd_val & s.mask) != s.exp);
            if (s.data[0])
               check_bit("irq", 1'b1, irq_val);      // Same cycle as the hit
         end
         OP_SW:
         begin
            sw = s.data;
            @(posedge clk);
            #DRIVE_DLY;
         end
         default:                                    // OP_IRQ and OP_LD
         begin
            @(negedge clk);
            if (s.op == OP_IRQ)
               check_bit("irq", s.exp[0], irq);
            else
               check_data("ld", s.exp, ld);
            @(posedge clk);
            #DRIVE_DLY;
         end
      endcase
   endtask

   task automatic report_test(input int t);
      if (test_errs == 0)
         $display("Test %0d %s ok", t, test_name[t]);
      else
      begin
         tests_failed++;
         $display("Test %0d %s had %0d errors", t, test_name[t], test_errs);
      end
      test_errs = 0;
   endtask

   //**************************************************************************
   // Main sequence and watchdog
   //**************************************************************************
   initial
   begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      cpu_req      = 1'b0;
      cpu_bus      = '0;
      sw           = '0;
      errors       = 0;
      test_errs    = 0;
      tests_failed = 0;
      checks       = 0;
      table_ready  = 1'b0;
      void'($urandom(SEED));
      build_table();
      table_ready  = 1'b1;
      repeat (RST_CYCLES) @(posedge clk);
      #DRIVE_DLY;
      rst_n = 1'b1;
      @(posedge clk);
      #DRIVE_DLY;
      for (int i = 0; i < steps.size(); i++)
      begin
         run_step(steps[i]);
         if ((i == steps.size() - 1) || (steps[i + 1].test != steps[i].test))
            report_test(int'(steps[i].test));
      end
      $display("Tests %0d, failed %0d, checks %0d, errors %0d",
               N_TESTS, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

   initial
   begin
      longint unsigned limit;
      dma_state_t      st;
      wait (table_ready);
      limit = longint'(steps.size()) * 200 * CLK_PERIOD;   // 200 cycles per step
      #(limit);
      st = dut0.dma.state_q;
      $display("Watchdog expired at %0t with the DMA FSM in %s", $time, st.name());
      $display("Simulation failed");
      $finish;
   end

endmodule
